/* hw/riscv_isa_pkg.sv */
package riscv_isa_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // base word types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a raw 32-bit instruction as fetched from the instruction memory.
    typedef logic [31:0] instr_t;

    // one data word of the rv32 integer register file and the data bus.
    typedef logic [31:0] xlen_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field positions inside an instruction word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // each field is given by its lowest bit and its width.
    localparam int unsigned opcode_lsb = 0;
    localparam int unsigned opcode_w   = 7;
    localparam int unsigned rd_lsb     = 7;
    localparam int unsigned funct3_lsb = 12;
    localparam int unsigned funct3_w   = 3;
    localparam int unsigned rs1_lsb    = 15;
    localparam int unsigned rs2_lsb    = 20;
    localparam int unsigned funct7_lsb = 25;
    localparam int unsigned funct7_w   = 7;

    // all three register specifiers share this width.
    localparam int unsigned reg_addr_w = 5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes of the supported subset
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    // funct3 codes of the arithmetic and logic group.
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct7 with bit 30 set turns an add into a subtract.
    localparam logic [6:0] f7_sub = 7'b0100000;

endpackage

/* hw/riscv_ctrl_pkg.sv */
package riscv_ctrl_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alu operation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the four operations the alu can perform.
    typedef enum logic [1:0] {
        alu_op_add = 2'b00,
        alu_op_sub = 2'b01,
        alu_op_or  = 2'b10,
        alu_op_and = 2'b11
    } alu_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath select encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // second alu operand comes from rs2 or from the extended immediate.
    typedef enum logic {
        alu_src_reg     = 1'b0,
        alu_src_ext_imm = 1'b1
    } alu_src_t;

    // value written back to the destination register.
    typedef enum logic [1:0] {
        res_src_alu_out   = 2'b00,
        res_src_read_data = 2'b01,
        res_src_pc_plus_4 = 2'b10
    } result_src_t;

    // next program counter is sequential or pc relative.
    typedef enum logic {
        pc_src_plus_4   = 1'b0,
        pc_src_plus_off = 1'b1
    } pc_src_t;

    // instruction format that holds the immediate.
    typedef enum logic [1:0] {
        imm_src_itype = 2'b00,
        imm_src_stype = 2'b01,
        imm_src_btype = 2'b10,
        imm_src_jtype = 2'b11
    } imm_src_t;

endpackage

/* hw/core_ctrl_if.sv */
`timescale 1ns/1ps

// control bundle between the decoder and the datapath.
// everything here is combinational and settles within one cycle.
interface core_ctrl_if;

    // decoder outputs.
    logic                        reg_we;
    riscv_ctrl_pkg::alu_src_t    alu_src;
    riscv_ctrl_pkg::result_src_t result_src;
    riscv_ctrl_pkg::pc_src_t     pc_src;
    riscv_ctrl_pkg::imm_src_t    imm_src;
    riscv_ctrl_pkg::alu_op_t     alu_ctrl;

    // flag returned from the datapath, used to resolve beq.
    logic                        alu_zero;

    // the decoder side drives selects and reads the flag.
    modport ctrl (
        output reg_we, alu_src, result_src, pc_src, imm_src, alu_ctrl,
        input  alu_zero
    );

    // the datapath side consumes selects and returns the flag.
    modport dp (
        input  reg_we, alu_src, result_src, pc_src, imm_src, alu_ctrl,
        output alu_zero
    );

endinterface

/* hw/alu.sv */
`timescale 1ns/1ps

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer alu for the supported subset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// purely combinational, the result is ready in the same cycle.
module alu (
    input  riscv_isa_pkg::xlen_t    a,
    input  riscv_isa_pkg::xlen_t    b,
    input  riscv_ctrl_pkg::alu_op_t op,
    output riscv_isa_pkg::xlen_t    result,
    output logic                    zero
);
    always_comb begin
        case (op)
            riscv_ctrl_pkg::alu_op_add: result = a + b;
            // subtract also serves beq, which only looks at the zero flag.
            riscv_ctrl_pkg::alu_op_sub: result = a - b;
            riscv_ctrl_pkg::alu_op_or:  result = a | b;
            riscv_ctrl_pkg::alu_op_and: result = a & b;
            default:                    result = a + b;
        endcase
    end

    // the flag is raised for any all-zero result.
    assign zero = (result == '0);
endmodule

/* hw/imm_extend.sv */
`timescale 1ns/1ps

// collects the scattered immediate bits of each format into one word.
module imm_extend (
    input  riscv_isa_pkg::instr_t    instr,
    input  riscv_ctrl_pkg::imm_src_t imm_src,
    output riscv_isa_pkg::xlen_t     imm
);
    // every format keeps its sign in bit 31 of the instruction.
    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_src)
            // i-type, twelve bits straight from the top of the word.
            riscv_ctrl_pkg::imm_src_itype: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            // s-type, the low five bits sit where rd would be.
            riscv_ctrl_pkg::imm_src_stype: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            // b-type offsets are in halfwords, so bit 0 is always zero.
            riscv_ctrl_pkg::imm_src_btype: begin
                imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            // j-type gives a 21-bit halfword offset.
            riscv_ctrl_pkg::imm_src_jtype: begin
                imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = {{20{sign}}, instr[31:20]};
            end
        endcase
    end
endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer register file, x0 to x31
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// two asynchronous read ports and one write port on the rising edge.
module reg_file (
    input  logic                 clk,
    input  logic                 we,
    input  logic [4:0]           ra1,
    input  logic [4:0]           ra2,
    input  logic [4:0]           wa,
    input  riscv_isa_pkg::xlen_t wd,
    output riscv_isa_pkg::xlen_t rd1,
    output riscv_isa_pkg::xlen_t rd2
);
    // storage for all 32 entries. entry 0 is never written.
    riscv_isa_pkg::xlen_t regs [32];

    // a write to x0 is dropped, the architecture fixes it at zero.
    always_ff @(posedge clk) begin
        if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // reads see the old value when the same register is written this
    // cycle. x0 is forced to zero here since its entry is never loaded.
    always_comb begin
        if (ra1 == 5'd0) begin
            rd1 = '0;
        end else begin
            rd1 = regs[ra1];
        end
    end

    always_comb begin
        if (ra2 == 5'd0) begin
            rd2 = '0;
        end else begin
            rd2 = regs[ra2];
        end
    end
endmodule

/* hw/controller.sv */
`timescale 1ns/1ps

// picks the alu operation from the opcode and the function fields.
module alu_dec (
    input  logic [6:0]              op,
    input  logic [2:0]              func3,
    input  logic [6:0]              func7,
    output riscv_ctrl_pkg::alu_op_t alu_ctrl
);
    // operation implied by funct3 for the arithmetic group.
    riscv_ctrl_pkg::alu_op_t arith_op;

    always_comb begin
        case (func3)
            riscv_isa_pkg::f3_add_sub: begin
                // only register forms may subtract. an addi whose immediate
                // carries the subtract pattern in its top bits must still add.
                if (op == riscv_isa_pkg::op_reg && func7 == riscv_isa_pkg::f7_sub) begin
                    arith_op = riscv_ctrl_pkg::alu_op_sub;
                end else begin
                    arith_op = riscv_ctrl_pkg::alu_op_add;
                end
            end
            riscv_isa_pkg::f3_or:  arith_op = riscv_ctrl_pkg::alu_op_or;
            riscv_isa_pkg::f3_and: arith_op = riscv_ctrl_pkg::alu_op_and;
            default:               arith_op = riscv_ctrl_pkg::alu_op_add;
        endcase
    end

    // loads, stores and jal compute addresses, beq compares by subtracting.
    always_comb begin
        case (op)
            riscv_isa_pkg::op_reg,
            riscv_isa_pkg::op_imm:    alu_ctrl = arith_op;
            riscv_isa_pkg::op_branch: alu_ctrl = riscv_ctrl_pkg::alu_op_sub;
            default:                  alu_ctrl = riscv_ctrl_pkg::alu_op_add;
        endcase
    end
endmodule

// main decoder, turns the fetched instruction into datapath controls.
module controller (
    input  riscv_isa_pkg::instr_t instr,
    output logic                  mem_we,
    core_ctrl_if.ctrl             ctl
);
    // one row of the decode table.
    typedef struct packed {
        logic                        reg_we;
        logic                        mem_we;
        riscv_ctrl_pkg::alu_src_t    alu_src;
        riscv_ctrl_pkg::result_src_t result_src;
        riscv_ctrl_pkg::pc_src_t     pc_src;
        riscv_ctrl_pkg::imm_src_t    imm_src;
    } ctrl_word_t;

    logic [6:0]              op;
    logic [2:0]              func3;
    logic [6:0]              func7;
    riscv_ctrl_pkg::pc_src_t beq_pc_src;
    ctrl_word_t              ctrls;

    assign op    = instr[riscv_isa_pkg::opcode_lsb +: riscv_isa_pkg::opcode_w];
    assign func3 = instr[riscv_isa_pkg::funct3_lsb +: riscv_isa_pkg::funct3_w];
    assign func7 = instr[riscv_isa_pkg::funct7_lsb +: riscv_isa_pkg::funct7_w];

    alu_dec u_alu_dec (
        .op       (op),
        .func3    (func3),
        .func7    (func7),
        .alu_ctrl (ctl.alu_ctrl)
    );

    // the branch is taken when rs1 minus rs2 is zero.
    always_comb begin
        if (ctl.alu_zero) begin
            beq_pc_src = riscv_ctrl_pkg::pc_src_plus_off;
        end else begin
            beq_pc_src = riscv_ctrl_pkg::pc_src_plus_4;
        end
    end

    // unused fields in a row hold harmless values. an unknown opcode
    // writes nothing and falls through to the next word.
    always_comb begin
        case (op)
            //                          reg_we mem_we alu_src
            //                          result_src pc_src imm_src
            riscv_isa_pkg::op_load:   ctrls = '{1'b1, 1'b0, riscv_ctrl_pkg::alu_src_ext_imm,
                riscv_ctrl_pkg::res_src_read_data, riscv_ctrl_pkg::pc_src_plus_4,
                riscv_ctrl_pkg::imm_src_itype};
            riscv_isa_pkg::op_imm:    ctrls = '{1'b1, 1'b0, riscv_ctrl_pkg::alu_src_ext_imm,
                riscv_ctrl_pkg::res_src_alu_out, riscv_ctrl_pkg::pc_src_plus_4,
                riscv_ctrl_pkg::imm_src_itype};
            riscv_isa_pkg::op_store:  ctrls = '{1'b0, 1'b1, riscv_ctrl_pkg::alu_src_ext_imm,
                riscv_ctrl_pkg::res_src_alu_out, riscv_ctrl_pkg::pc_src_plus_4,
                riscv_ctrl_pkg::imm_src_stype};
            riscv_isa_pkg::op_reg:    ctrls = '{1'b1, 1'b0, riscv_ctrl_pkg::alu_src_reg,
                riscv_ctrl_pkg::res_src_alu_out, riscv_ctrl_pkg::pc_src_plus_4,
                riscv_ctrl_pkg::imm_src_itype};
            riscv_isa_pkg::op_branch: ctrls = '{1'b0, 1'b0, riscv_ctrl_pkg::alu_src_reg,
                riscv_ctrl_pkg::res_src_alu_out, beq_pc_src,
                riscv_ctrl_pkg::imm_src_btype};
            riscv_isa_pkg::op_jal:    ctrls = '{1'b1, 1'b0, riscv_ctrl_pkg::alu_src_reg,
                riscv_ctrl_pkg::res_src_pc_plus_4, riscv_ctrl_pkg::pc_src_plus_off,
                riscv_ctrl_pkg::imm_src_jtype};
            default:                  ctrls = '{1'b0, 1'b0, riscv_ctrl_pkg::alu_src_reg,
                riscv_ctrl_pkg::res_src_alu_out, riscv_ctrl_pkg::pc_src_plus_4,
                riscv_ctrl_pkg::imm_src_itype};
        endcase
    end

    assign ctl.reg_we     = ctrls.reg_we;
    assign mem_we         = ctrls.mem_we;
    assign ctl.alu_src    = ctrls.alu_src;
    assign ctl.result_src = ctrls.result_src;
    assign ctl.pc_src     = ctrls.pc_src;
    assign ctl.imm_src    = ctrls.imm_src;
endmodule

/* hw/datapath.sv */
`timescale 1ns/1ps

// program counter, register file, immediate unit and alu with their muxes.
module datapath #(
    parameter riscv_isa_pkg::xlen_t reset_pc = 32'h0000_0000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  riscv_isa_pkg::instr_t instr,
    input  riscv_isa_pkg::xlen_t  mem_rdata,
    output riscv_isa_pkg::xlen_t  pc,
    output riscv_isa_pkg::xlen_t  mem_addr,
    output riscv_isa_pkg::xlen_t  mem_wdata,
    core_ctrl_if.dp               ctl
);
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [4:0]           rd;
    logic                 rf_we;
    riscv_isa_pkg::xlen_t rd1;
    riscv_isa_pkg::xlen_t rd2;
    riscv_isa_pkg::xlen_t ext_imm;
    riscv_isa_pkg::xlen_t alu_b;
    riscv_isa_pkg::xlen_t alu_out;
    logic                 alu_zero;
    riscv_isa_pkg::xlen_t result;
    riscv_isa_pkg::xlen_t pc_plus_4;
    riscv_isa_pkg::xlen_t pc_plus_off;
    riscv_isa_pkg::xlen_t pc_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign pc_plus_4   = pc + 32'd4;
    // branch and jump targets are both relative to the current pc.
    assign pc_plus_off = pc + ext_imm;

    always_comb begin
        case (ctl.pc_src)
            riscv_ctrl_pkg::pc_src_plus_off: pc_next = pc_plus_off;
            default:                         pc_next = pc_plus_4;
        endcase
    end

    // the first instruction after reset is the one at reset_pc.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register file and operands
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rs1 = instr[riscv_isa_pkg::rs1_lsb +: riscv_isa_pkg::reg_addr_w];
    assign rs2 = instr[riscv_isa_pkg::rs2_lsb +: riscv_isa_pkg::reg_addr_w];
    assign rd  = instr[riscv_isa_pkg::rd_lsb  +: riscv_isa_pkg::reg_addr_w];

    // no architectural state changes while reset is held.
    assign rf_we = ctl.reg_we && !rst;

    reg_file u_reg_file (
        .clk (clk),
        .we  (rf_we),
        .ra1 (rs1),
        .ra2 (rs2),
        .wa  (rd),
        .wd  (result),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    imm_extend u_imm_extend (
        .instr   (instr),
        .imm_src (ctl.imm_src),
        .imm     (ext_imm)
    );

    always_comb begin
        case (ctl.alu_src)
            riscv_ctrl_pkg::alu_src_ext_imm: alu_b = ext_imm;
            default:                         alu_b = rd2;
        endcase
    end

    alu u_alu (
        .a      (rd1),
        .b      (alu_b),
        .op     (ctl.alu_ctrl),
        .result (alu_out),
        .zero   (alu_zero)
    );

    assign ctl.alu_zero = alu_zero;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory access and write back
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // loads and stores address memory with rs1 plus the offset.
    assign mem_addr  = alu_out;
    assign mem_wdata = rd2;

    always_comb begin
        case (ctl.result_src)
            riscv_ctrl_pkg::res_src_read_data: result = mem_rdata;
            riscv_ctrl_pkg::res_src_pc_plus_4: result = pc_plus_4;
            default:                           result = alu_out;
        endcase
    end
endmodule

/* hw/riscv_core.sv */
`timescale 1ns/1ps

// single-cycle core. one instruction retires on every rising clock edge.
// fetch and data memory sit outside and answer in the same cycle.
module riscv_core #(
    parameter riscv_isa_pkg::xlen_t reset_pc = 32'h0000_0000
) (
    input  logic                  clk,
    input  logic                  rst,

    // instruction fetch.
    output riscv_isa_pkg::xlen_t  pc,
    input  riscv_isa_pkg::instr_t instr,

    // data memory, written on the edge that ends a store.
    output logic                  mem_we,
    output riscv_isa_pkg::xlen_t  mem_addr,
    output riscv_isa_pkg::xlen_t  mem_wdata,
    input  riscv_isa_pkg::xlen_t  mem_rdata
);
    // control bundle between the two halves of the core.
    core_ctrl_if ctl_if ();

    controller u_controller (
        .instr  (instr),
        .mem_we (mem_we),
        .ctl    (ctl_if.ctrl)
    );

    datapath #(
        .reset_pc (reset_pc)
    ) u_datapath (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .mem_rdata (mem_rdata),
        .pc        (pc),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .ctl       (ctl_if.dp)
    );
endmodule

/* testbench/tb_riscv_core.sv */
`timescale 1ns/1ps

module tb_riscv_core;

    // the program starts inside the memory so that pc 0 is not the first fetch.
    localparam riscv_isa_pkg::xlen_t reset_pc = 32'h0000_0040;
    localparam int reset_cycles = 16;
    localparam int max_steps    = 200;

    // row kinds of the program table.
    localparam int k_lw   = 0;
    localparam int k_sw   = 1;
    localparam int k_addi = 2;
    localparam int k_ori  = 3;
    localparam int k_andi = 4;
    localparam int k_add  = 5;
    localparam int k_sub  = 6;
    localparam int k_or   = 7;
    localparam int k_and  = 8;
    localparam int k_beq  = 9;
    localparam int k_jal  = 10;
    localparam int k_bad  = 11;

    logic                  clk;
    logic                  rst;
    riscv_isa_pkg::xlen_t  pc;
    riscv_isa_pkg::instr_t instr;
    logic                  mem_we;
    riscv_isa_pkg::xlen_t  mem_addr;
    riscv_isa_pkg::xlen_t  mem_wdata;
    riscv_isa_pkg::xlen_t  mem_rdata;

    // memory models, 64 words each, indexed by address bits 7 to 2.
    riscv_isa_pkg::instr_t imem [64];
    riscv_isa_pkg::xlen_t  dmem [64];

    // state of the reference interpreter.
    riscv_isa_pkg::xlen_t  ref_mem [64];
    riscv_isa_pkg::xlen_t  ref_regs [32];

    // program table, one entry per row in every queue.
    int                    t_kind [$];
    logic [4:0]            t_rd [$];
    logic [4:0]            t_rs1 [$];
    logic [4:0]            t_rs2 [$];
    riscv_isa_pkg::xlen_t  t_imm [$];
    riscv_isa_pkg::instr_t t_word [$];

    // expected pc per cycle and expected stores in program order.
    riscv_isa_pkg::xlen_t  exp_pc [$];
    riscv_isa_pkg::xlen_t  exp_st_addr [$];
    riscv_isa_pkg::xlen_t  exp_st_data [$];

    int   errors = 0;
    int   checks = 0;
    int   cycles = 0;
    int   limit  = 0;
    logic done   = 1'b0;

    riscv_core #(
        .reset_pc (reset_pc)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .pc        (pc),
        .instr     (instr),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory models
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // both memories answer combinationally within the cycle.
    assign instr     = imem[pc[7:2]];
    assign mem_rdata = dmem[mem_addr[7:2]];

    // stores land on the edge that ends the store cycle, never in reset.
    always @(posedge clk) begin
        if (mem_we === 1'b1 && !rst) begin
            dmem[mem_addr[7:2]] <= mem_wdata;
        end
    end

    // the run is cut off if the trace has not been walked in time.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit && !done) begin
            $display("timeout, the program did not finish within %0d cycles", limit);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR time %0t %s expected %08h actual %08h",
                     $time, name, expected, actual);
        end
    endtask

    // assembles one row from its fields and appends it to the table.
    task automatic add_row(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [4:0] rs2, input riscv_isa_pkg::xlen_t imm);
        riscv_isa_pkg::instr_t w;
        case (kind)
            // funct3 010 is the word width for lw and sw.
            k_lw:   w = {imm[11:0], rs1, 3'b010, rd, riscv_isa_pkg::op_load};
            k_sw:   w = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], riscv_isa_pkg::op_store};
            k_addi: w = {imm[11:0], rs1, riscv_isa_pkg::f3_add_sub, rd, riscv_isa_pkg::op_imm};
            k_ori:  w = {imm[11:0], rs1, riscv_isa_pkg::f3_or, rd, riscv_isa_pkg::op_imm};
            k_andi: w = {imm[11:0], rs1, riscv_isa_pkg::f3_and, rd, riscv_isa_pkg::op_imm};
            k_add:  w = {7'b0, rs2, rs1, riscv_isa_pkg::f3_add_sub, rd, riscv_isa_pkg::op_reg};
            k_sub:  w = {riscv_isa_pkg::f7_sub, rs2, rs1, riscv_isa_pkg::f3_add_sub, rd,
                         riscv_isa_pkg::op_reg};
            k_or:   w = {7'b0, rs2, rs1, riscv_isa_pkg::f3_or, rd, riscv_isa_pkg::op_reg};
            k_and:  w = {7'b0, rs2, rs1, riscv_isa_pkg::f3_and, rd, riscv_isa_pkg::op_reg};
            k_beq:  w = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11],
                         riscv_isa_pkg::op_branch};
            k_jal:  w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscv_isa_pkg::op_jal};
            // opcode 1111111 is outside the subset.
            default: w = {20'h01234, rd, 7'b1111111};
        endcase
        t_kind.push_back(kind);
        t_rd.push_back(rd);
        t_rs1.push_back(rs1);
        t_rs2.push_back(rs2);
        t_imm.push_back(imm);
        t_word.push_back(w);
    endtask

    task automatic build_program();
        riscv_isa_pkg::xlen_t imm_a;
        riscv_isa_pkg::xlen_t imm_b;
        riscv_isa_pkg::xlen_t imm_c;
        riscv_isa_pkg::xlen_t imm_d;
        logic [11:0]          r;
        // imm_a is always negative to exercise the sign extension.
        r = $urandom();
        imm_a = {{21{1'b1}}, r[10:0]};
        r = $urandom();
        imm_b = {{20{r[11]}}, r};
        r = $urandom();
        imm_c = {{20{r[11]}}, r};
        // imm_d carries the subtract pattern of funct7 in its top bits.
        r = $urandom();
        imm_d = {20'h0, riscv_isa_pkg::f7_sub, r[4:0]};
        add_row(k_lw,   1, 0, 0, 0);
        add_row(k_lw,   2, 0, 0, 4);
        add_row(k_addi, 3, 1, 0, imm_a);
        add_row(k_ori,  4, 3, 0, imm_b);
        add_row(k_andi, 5, 4, 0, imm_c);
        add_row(k_sw,   0, 0, 5, 128);
        // an addi must still add when its immediate looks like a sub.
        add_row(k_addi, 11, 2, 0, imm_d);
        add_row(k_sw,   0, 0, 11, 168);
        add_row(k_add,  6, 1, 2, 0);
        add_row(k_sub,  7, 1, 2, 0);
        add_row(k_or,   8, 1, 2, 0);
        add_row(k_and,  9, 1, 2, 0);
        add_row(k_sw,   0, 0, 6, 132);
        add_row(k_sw,   0, 0, 7, 136);
        add_row(k_sw,   0, 0, 8, 140);
        add_row(k_sw,   0, 0, 9, 144);
        // the sum aimed at x0 must vanish.
        add_row(k_add,  0, 1, 2, 0);
        add_row(k_sw,   0, 0, 0, 148);
        // taken branch over a store, then one whose operands always differ
        // since x3 is x1 plus a nonzero negative immediate.
        add_row(k_beq,  0, 1, 1, 8);
        add_row(k_sw,   0, 0, 1, 152);
        add_row(k_beq,  0, 1, 3, 8);
        add_row(k_sw,   0, 0, 2, 156);
        add_row(k_jal, 10, 0, 0, 8);
        add_row(k_sw,   0, 0, 1, 160);
        // the unknown word names x10 as rd and must leave it untouched.
        add_row(k_bad, 10, 0, 0, 0);
        add_row(k_sw,   0, 0, 10, 164);
        // jal x0 to itself holds the core at the end of the program.
        add_row(k_jal,  0, 0, 0, 0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference interpreter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic run_reference();
        riscv_isa_pkg::xlen_t rpc;
        riscv_isa_pkg::xlen_t next;
        riscv_isa_pkg::xlen_t halt_pc;
        riscv_isa_pkg::xlen_t a;
        riscv_isa_pkg::xlen_t b;
        riscv_isa_pkg::xlen_t res;
        riscv_isa_pkg::xlen_t imm;
        logic                 wr;
        int                   idx;
        int                   kind;
        int                   steps;
        rpc = reset_pc;
        halt_pc = reset_pc + 4 * (t_kind.size() - 1);
        steps = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        while (steps < max_steps) begin
            exp_pc.push_back(rpc);
            if (rpc == halt_pc) begin
                break;
            end
            idx = int'((rpc - reset_pc) >> 2);
            // anything outside the table reads as an all-zero word, which is a no-op.
            kind = (idx < t_kind.size()) ? t_kind[idx] : k_bad;
            a = (kind == k_bad) ? '0 : ref_regs[t_rs1[idx]];
            b = (kind == k_bad) ? '0 : ref_regs[t_rs2[idx]];
            imm = (kind == k_bad) ? '0 : t_imm[idx];
            next = rpc + 4;
            wr = 1'b1;
            res = '0;
            case (kind)
                k_lw:   res = ref_mem[(a + imm) >> 2 & 32'h3f];
                k_sw: begin
                    wr = 1'b0;
                    exp_st_addr.push_back(a + imm);
                    exp_st_data.push_back(b);
                    ref_mem[(a + imm) >> 2 & 32'h3f] = b;
                end
                k_addi: res = a + imm;
                k_ori:  res = a | imm;
                k_andi: res = a & imm;
                k_add:  res = a + b;
                k_sub:  res = a - b;
                k_or:   res = a | b;
                k_and:  res = a & b;
                k_beq: begin
                    wr = 1'b0;
                    if (a == b) begin
                        next = rpc + imm;
                    end
                end
                k_jal: begin
                    res = rpc + 4;
                    next = rpc + imm;
                end
                default: wr = 1'b0;
            endcase
            if (wr && t_rd[idx] != 5'd0) begin
                ref_regs[t_rd[idx]] = res;
            end
            rpc = next;
            steps++;
        end
        if (steps >= max_steps) begin
            errors++;
            $display("the reference run never reached the end of the program");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int unsigned seed_word;
        seed_word = $urandom(32'haf56);
        rst = 1'b1;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = $urandom();
            ref_mem[i] = dmem[i];
            imem[i] = '0;
        end
        build_program();
        foreach (t_word[i]) begin
            imem[reset_pc[7:2] + i] = t_word[i];
        end
        run_reference();
        limit = reset_cycles + exp_pc.size() + 20;

        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        // entry i is the instruction executing between two rising edges.
        // outputs are sampled at the falling edge where they have settled.
        foreach (exp_pc[i]) begin
            @(negedge clk);
            check("pc", exp_pc[i], pc);
            if (mem_we === 1'b1) begin
                if (exp_st_addr.size() == 0) begin
                    errors++;
                    $display("a store at pc %08h was not expected", pc);
                end else begin
                    check("mem_addr", exp_st_addr.pop_front(), mem_addr);
                    check("mem_wdata", exp_st_data.pop_front(), mem_wdata);
                end
            end
        end
        done = 1'b1;
        if (exp_st_addr.size() != 0) begin
            errors++;
            $display("%0d expected stores never happened", exp_st_addr.size());
        end

        $display("errors %0d, checks %0d", errors, checks);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* riscv_core.f */
hw/riscv_isa_pkg.sv
hw/riscv_ctrl_pkg.sv
hw/core_ctrl_if.sv
hw/alu.sv
hw/imm_extend.sv
hw/reg_file.sv
hw/controller.sv
hw/datapath.sv
hw/riscv_core.sv
testbench/tb_riscv_core.sv
